/* tb/kbd_tests.txt */
# name kind(frame|partial) byte(hex) parity_good expected_key expected_frame_errors
# key and error count are checked after the line, key in decimal
make_a          frame   1c 1 97  0
make_kp9        frame   7d 1 57  0
make_f1         frame   05 1 141 0
make_digit5     frame   2e 1 53  0
make_kp5        frame   73 1 53  0
make_z          frame   1a 1 122 0
break_prefix    frame   f0 1 122 0
break_z         frame   1a 1 0   0
make_space      frame   29 1 32  0
make_f12        frame   07 1 152 0
make_escape     frame   76 1 140 0
make_enter      frame   5a 1 128 0
ext_prefix_1    frame   e0 1 128 0
ext_up          frame   75 1 131 0
ext_prefix_2    frame   e0 1 131 0
ext_kp_enter    frame   5a 1 128 0
plain_kp8       frame   75 1 56  0
ext_prefix_3    frame   e0 1 56  0
ext_break_pfx   frame   f0 1 56  0
ext_break_up    frame   75 1 0   0
unmapped_shift  frame   12 1 0   0
make_q          frame   15 1 113 0
unmapped_caps   frame   58 1 0   0
make_tab        frame   0d 1 9   0
bad_parity      frame   1c 0 9   1
make_backspace  frame   66 1 129 0
partial_frame   partial 55 1 129 1
after_timeout   frame   1c 1 97  0
ext_prefix_4    frame   e0 1 97  0
ext_left        frame   6b 1 130 0
plain_slash     frame   4a 1 47  0
ext_prefix_5    frame   e0 1 47  0
ext_delete      frame   71 1 139 0

/* filelist.f */
+incdir+design
design/kbd_pkg.sv
design/ps2_rx.sv
design/scan_to_key.sv
design/kbd_top.sv
tb/kbd_tb.sv

/* Bender.yml */
package:
  name: ps2_kbd

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/kbd_pkg.sv
      - design/ps2_rx.sv
      - design/scan_to_key.sv
      - design/kbd_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/kbd_tb.sv

/* tb/kbd_tb.sv */
`timescale 1ns/100ps

`include "kbd_params.svh"

module kbd_tb import kbd_pkg::*; ();

    localparam int CLK_HALF  = 20;   // 40 ns system clock
    localparam int PS2_HALF  = 20;   // system clocks per PS/2 half period
    localparam int GAP_MIN   = 30;
    localparam int GAP_BITS  = 6;    // gap of 30 to 93 cycles
    localparam int SETTLE    = 10;
    localparam int LINE_COST = `KBD_RX_TIMEOUT + 600;

    logic      clk;
    logic      rst_n;
    logic      ps2_clk;
    logic      ps2_data;
    key_code_t key;
    logic      frame_error;

    // test table, one entry per data line
    string      t_name[$];
    string      t_kind[$];
    scan_byte_t t_byte[$];
    int         t_par_ok[$];
    int         t_exp_key[$];
    int         t_exp_err[$];

    logic [31:0] lfsr_state  = 32'ha168_2940;
    int          err_count   = 0;   // frame_error pulses seen so far
    int          cycle_limit = 0;
    int          cycle_cnt   = 0;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;

    kbd_top kbd_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key         (key),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        if (frame_error) begin
            err_count <= err_count + 1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // start, 8 data lsb first, odd parity, stop
    function automatic logic [10:0] build_frame(input scan_byte_t data, input int par_ok);
        logic par;
        par = ~^data;
        if (par_ok == 0) begin
            par = ~par;
        end
        return {1'b1, par, data, 1'b0};
    endfunction

    // device side of the bus, data changes while the clock is high
    task automatic drive_bits(input logic [10:0] frame, input int n_bits);
        for (int i = 0; i < n_bits; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            wait_cycles(PS2_HALF);
            ps2_clk <= 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
    endtask

    task automatic load_tests(output bit ok);
        int         fd;
        int         n;
        string      line;
        string      name;
        string      kind;
        scan_byte_t code;
        int         par_ok;
        int         exp_key;
        int         exp_err;
        ok = 1'b1;
        fd = $fopen("tb/kbd_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file tb/kbd_tests.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %d %d %d",
                                name, kind, code, par_ok, exp_key, exp_err);
                    if (n == 6) begin
                        t_name.push_back(name);
                        t_kind.push_back(kind);
                        t_byte.push_back(code);
                        t_par_ok.push_back(par_ok);
                        t_exp_key.push_back(exp_key);
                        t_exp_err.push_back(exp_err);
                    end else if (n > 0) begin
                        $display("malformed line in the test file: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (t_name.size() == 0) begin
                $display("the test file holds no tests");
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_test(input int t);
        int  gap;
        int  err_before;
        int  err_seen;
        bit  test_ok;
        test_ok = 1'b1;
        draw_bits(GAP_BITS, gap);
        wait_cycles(GAP_MIN + gap); // idle between frames
        err_before = err_count;
        if (t_kind[t] == "frame") begin
            drive_bits(build_frame(t_byte[t], t_par_ok[t]), 11);
        end else if (t_kind[t] == "partial") begin
            drive_bits(build_frame(t_byte[t], t_par_ok[t]), 5);
            wait_cycles(`KBD_RX_TIMEOUT + 200); // let the receiver give up
        end else begin
            $display("test %s has an unknown kind %s", t_name[t], t_kind[t]);
            test_ok = 1'b0;
        end
        wait_cycles(SETTLE);
        err_seen = err_count - err_before;
        assert (key == key_code_t'(t_exp_key[t])) else begin
            $display("FAILED %s: key expected %0d, actual %0d",
                     t_name[t], t_exp_key[t], key);
            test_ok = 1'b0;
        end
        assert (err_seen == t_exp_err[t]) else begin
            $display("FAILED %s: frame_error pulses expected %0d, actual %0d",
                     t_name[t], t_exp_err[t], err_seen);
            test_ok = 1'b0;
        end
        if (test_ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("%-16s %-7s %h  key %0d  errors %0d  %s", t_name[t], t_kind[t],
                 t_byte[t], key, err_seen, test_ok ? "ok" : "bad");
    endtask

    // watchdog, armed once the test count is known
    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        bit loaded;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1; // bus idles high
        ps2_data = 1'b1;
        load_tests(loaded);
        if (!loaded) begin
            $display("no tests could be run");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            cycle_limit = t_name.size() * LINE_COST;
            wait_cycles(2);
            rst_n <= 1'b1;
            wait_cycles(2);
            for (int t = 0; t < t_name.size(); t++) begin
                run_test(t);
            end
            $display("tests run %0d, passed %0d, failed %0d",
                     pass_cnt + fail_cnt, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

/* design/kbd_top.sv */
`timescale 1ns/100ps

module kbd_top import kbd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    output key_code_t key,
    output logic      frame_error
);

    logic       scan_ready; // one-cycle byte strobe
    scan_byte_t scan_code;

    ps2_rx ps2_rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .scan_ready  (scan_ready),
        .scan_code   (scan_code),
        .frame_error (frame_error)
    );

    // key is a level, updated one cycle after scan_ready
    scan_to_key scan_to_key_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_ready (scan_ready),
        .scan_code  (scan_code),
        .key        (key)
    );

endmodule

/* design/scan_to_key.sv */
`timescale 1ns/100ps

`include "kbd_params.svh"

module scan_to_key import kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scan_ready,
    input  scan_byte_t scan_code,
    output key_code_t  key
);

    prefix_e   prefix_q;
    key_code_t key_q;
    logic      is_ext;
    logic      is_break;

    // set-2 codes without prefix
    function automatic key_code_t base_key(input scan_byte_t code);
        case (code)
            8'h0d: return 8'd9;   // tab
            8'h29: return 8'd32;  // space
            8'h52: return 8'd39;  // '
            8'h7c: return 8'd42;  // kp *
            8'h79: return 8'd43;  // kp +
            8'h41: return 8'd44;  // ,
            8'h4e: return 8'd45;  // -
            8'h7b: return 8'd45;  // kp -
            8'h49: return 8'd46;  // .
            8'h71: return 8'd46;  // kp .
            8'h4a: return 8'd47;  // /
            8'h45: return 8'd48;  // 0
            8'h70: return 8'd48;  // kp 0
            8'h16: return 8'd49;
            8'h69: return 8'd49;
            8'h1e: return 8'd50;
            8'h72: return 8'd50;
            8'h26: return 8'd51;
            8'h7a: return 8'd51;
            8'h25: return 8'd52;
            8'h6b: return 8'd52;
            8'h2e: return 8'd53;
            8'h73: return 8'd53;
            8'h36: return 8'd54;
            8'h74: return 8'd54;
            8'h3d: return 8'd55;
            8'h6c: return 8'd55;
            8'h3e: return 8'd56;
            8'h75: return 8'd56;
            8'h46: return 8'd57;  // 9
            8'h7d: return 8'd57;  // kp 9
            8'h4c: return 8'd59;  // ;
            8'h55: return 8'd61;  // =
            8'h54: return 8'd91;  // [
            8'h5d: return 8'd92;  // backslash
            8'h5b: return 8'd93;  // ]
            8'h0e: return 8'd96;  // `
            8'h1c: return 8'd97;  // a
            8'h32: return 8'd98;
            8'h21: return 8'd99;
            8'h23: return 8'd100;
            8'h24: return 8'd101;
            8'h2b: return 8'd102;
            8'h34: return 8'd103;
            8'h33: return 8'd104;
            8'h43: return 8'd105;
            8'h3b: return 8'd106;
            8'h42: return 8'd107;
            8'h4b: return 8'd108;
            8'h3a: return 8'd109;
            8'h31: return 8'd110;
            8'h44: return 8'd111;
            8'h4d: return 8'd112;
            8'h15: return 8'd113;
            8'h2d: return 8'd114;
            8'h1b: return 8'd115;
            8'h2c: return 8'd116;
            8'h3c: return 8'd117;
            8'h2a: return 8'd118;
            8'h1d: return 8'd119;
            8'h22: return 8'd120;
            8'h35: return 8'd121;
            8'h1a: return 8'd122; // z
            8'h5a: return 8'd128; // enter
            8'h66: return 8'd129; // backspace
            8'h76: return 8'd140; // escape
            8'h05: return 8'd141; // F1
            8'h06: return 8'd142;
            8'h04: return 8'd143;
            8'h0c: return 8'd144;
            8'h03: return 8'd145;
            8'h0b: return 8'd146;
            8'h83: return 8'd147;
            8'h0a: return 8'd148;
            8'h01: return 8'd149;
            8'h09: return 8'd150;
            8'h78: return 8'd151;
            8'h07: return 8'd152; // F12
            default: return 8'd0; // shift, ctrl, caps and the rest
        endcase
    endfunction

    // codes that follow an e0 prefix
    function automatic key_code_t ext_key(input scan_byte_t code);
        case (code)
            8'h6b: return 8'd130; // left
            8'h75: return 8'd131; // up
            8'h74: return 8'd132; // right
            8'h72: return 8'd133; // down
            8'h6c: return 8'd134; // home
            8'h69: return 8'd135; // end
            8'h7d: return 8'd136; // page up
            8'h7a: return 8'd137; // page down
            8'h70: return 8'd138; // insert
            8'h71: return 8'd139; // delete
            8'h5a: return 8'd128; // keypad enter
            8'h4a: return 8'd47;  // keypad slash
            default: return 8'd0;
        endcase
    endfunction

    assign is_ext   = (prefix_q == PFX_EXT) || (prefix_q == PFX_EXT_BREAK);
    assign is_break = (prefix_q == PFX_BREAK) || (prefix_q == PFX_EXT_BREAK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prefix_q <= PFX_NONE;
            key_q    <= '0;
        end else if (scan_ready) begin
            if (scan_code == `KBD_EXT_CODE) begin
                prefix_q <= PFX_EXT;
            end else if (scan_code == `KBD_BREAK_CODE) begin
                if (prefix_q == PFX_NONE) begin
                    prefix_q <= PFX_BREAK;
                end else if (prefix_q == PFX_EXT) begin
                    prefix_q <= PFX_EXT_BREAK;
                end
            end else begin
                if (is_break) begin
                    key_q <= '0; // any release clears the word
                end else if (is_ext) begin
                    key_q <= ext_key(scan_code);
                end else begin
                    key_q <= base_key(scan_code);
                end
                prefix_q <= PFX_NONE;
            end
        end
    end

    assign key = key_q;

    a_prefix_cleared: assert property (
        @(posedge clk) disable iff (!rst_n)
        (scan_ready && scan_code != `KBD_EXT_CODE && scan_code != `KBD_BREAK_CODE)
            |=> (prefix_q == PFX_NONE)
    );

endmodule

/* design/ps2_rx.sv */
`timescale 1ns/100ps

`include "kbd_params.svh"

module ps2_rx import kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       scan_ready,
    output scan_byte_t scan_code,
    output logic       frame_error
);

    localparam int FILT_W = $clog2(`KBD_FILTER_LEN);
    localparam int TMR_W  = $clog2(`KBD_RX_TIMEOUT + 1);

    logic [1:0]        clk_sync;   // 2-flop synchronizers
    logic [1:0]        data_sync;
    logic [FILT_W-1:0] filt_cnt;
    logic              clk_filt;
    logic              clk_filt_prev;
    logic              fall_edge;
    logic              rx_bit;

    rx_state_e         state_q;
    logic [2:0]        bit_cnt;
    scan_byte_t        shift_q;
    logic              parity_acc;
    logic              start_ok;
    logic [TMR_W-1:0]  timer;
    logic              timeout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11; // lines idle high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign rx_bit = data_sync[1];

    // glitch filter on the clock line
    // level only follows after FILTER_LEN samples in a row that disagree with it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filt_cnt      <= '0;
            clk_filt      <= 1'b1;
            clk_filt_prev <= 1'b1;
        end else begin
            clk_filt_prev <= clk_filt;
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;
            end else if (filt_cnt == FILT_W'(`KBD_FILTER_LEN - 1)) begin
                filt_cnt <= '0;
                clk_filt <= clk_sync[1];
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    assign fall_edge = clk_filt_prev & ~clk_filt;

    // gap timer between edges, idle keeps it cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
        end else if (state_q == RX_IDLE || fall_edge) begin
            timer <= '0;
        end else if (timer != TMR_W'(`KBD_RX_TIMEOUT)) begin
            timer <= timer + 1'b1;
        end
    end

    assign timeout = (state_q != RX_IDLE) && !fall_edge &&
                     (timer == TMR_W'(`KBD_RX_TIMEOUT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            bit_cnt     <= '0;
            parity_acc  <= 1'b0;
            start_ok    <= 1'b0;
            scan_ready  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            scan_ready  <= 1'b0; // pulses by default
            frame_error <= 1'b0;
            if (timeout) begin
                state_q     <= RX_IDLE; // drop the partial frame
                frame_error <= 1'b1;
            end else if (fall_edge) begin
                case (state_q)
                    RX_IDLE: begin
                        start_ok   <= ~rx_bit; // checked with the stop bit
                        parity_acc <= 1'b0;
                        bit_cnt    <= '0;
                        state_q    <= RX_DATA;
                    end
                    RX_DATA: begin
                        parity_acc <= parity_acc ^ rx_bit;
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state_q <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        parity_acc <= parity_acc ^ rx_bit;
                        state_q    <= RX_STOP;
                    end
                    RX_STOP: begin
                        // odd parity means the running xor ends at 1
                        if (start_ok && parity_acc && rx_bit) begin
                            scan_ready <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state_q <= RX_IDLE;
                    end
                    default: state_q <= RX_IDLE;
                endcase
            end
        end
    end

    // data shifter, lsb arrives first
    always_ff @(posedge clk) begin
        if (fall_edge && state_q == RX_DATA) begin
            shift_q <= {rx_bit, shift_q[7:1]};
        end
    end

    assign scan_code = shift_q; // held stable until the next frame

    a_pulses_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(scan_ready && frame_error)
    );

    a_ready_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_ready |=> !scan_ready
    );

    a_error_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_error |=> !frame_error
    );

endmodule

/* design/kbd_pkg.sv */
package kbd_pkg;

    // raw byte from the PS/2 receiver
    typedef logic [7:0] scan_byte_t;

    // machine key code, 0 is no key
    typedef logic [7:0] key_code_t;

    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for start bit
        RX_DATA,   // eight data bits, lsb first
        RX_PARITY, // odd parity bit
        RX_STOP    // stop bit and frame check
    } rx_state_e;

    typedef enum logic [1:0] {
        PFX_NONE,
        PFX_EXT,      // e0 seen
        PFX_BREAK,    // f0 seen
        PFX_EXT_BREAK // e0 f0 seen
    } prefix_e;

endpackage

/* design/kbd_params.svh */
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// consecutive equal ps2_clk samples before the filtered level flips
`define KBD_FILTER_LEN 8

// system clocks allowed between two filtered falling edges in a frame
`define KBD_RX_TIMEOUT 4000

// set-2 prefix bytes
`define KBD_BREAK_CODE 8'hf0
`define KBD_EXT_CODE   8'he0

`endif
